//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = router_channel_tb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- channel_source/channel_source.sv
module channel_source #(
    parameter int   sinks  = 2,
    parameter int   lanes  = 2,
    parameter int   mot    = 4,
    parameter int   buffer = 1,
    localparam int  sink_w = router_ctrl_pkg::idx_w(sinks),
    localparam int  lane_w = router_ctrl_pkg::idx_w(lanes)
) (
    input  logic                  clk,
    input  logic                  rst,

    output logic                  cmd_full,
    input  logic                  cmd_push,
    input  logic [sink_w-1:0]     cmd_sink,

    output logic                  source_ready,
    input  logic                  source_valid,
    input  router_beat_pkg::beat_t source_beat,

    input  logic [sinks-1:0]      sink_source,

    output logic                  arb_req,
    output logic [sink_w-1:0]     arb_req_sink,
    input  logic                  arb_grant,
    input  logic [lane_w-1:0]     arb_grant_lane,

    input  logic [lanes-1:0]      lane_in_ready,
    output logic                  lane_in_valid,
    output router_beat_pkg::beat_t lane_in_beat
);

    logic              cmd_empty;
    logic              buf_ready;   // lane side may take a beat
    logic              grant;
    logic              grant_mask;  // doubles as the delayed FIFO pop
    logic              grant_clear;
    logic [lane_w-1:0] lane;

    // destination of the next packet, popped the cycle after its grant
    cmd_fifo #(
        .width (sink_w),
        .depth (mot)
    ) u_cmd_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (cmd_push),
        .push_data   (cmd_sink),
        .almost_full (cmd_full),
        .pop         (grant_mask),
        .pop_data    (arb_req_sink),
        .empty       (cmd_empty)
    );

    if (buffer > 0) begin : g_buffer
        router_beat_pkg::beat_t [1:0] buf_mem;
        logic [1:0] buf_cnt;
        logic [1:0] cnt_next;
        logic       in_ready;
        logic       push;
        logic       pop;
        logic       wr_slot;

        assign push    = source_valid && in_ready;
        assign pop     = buf_ready && (buf_cnt != 2'd0);
        assign wr_slot = (buf_cnt == 2'd2) || (buf_cnt == 2'd1 && !pop);

        always_comb begin
            case ({push, pop})
                2'b10:   cnt_next = buf_cnt + 2'd1;
                2'b01:   cnt_next = buf_cnt - 2'd1;
                default: cnt_next = buf_cnt;
            endcase
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                buf_cnt  <= 2'd0;
                in_ready <= 1'b0;
            end else begin
                buf_cnt  <= cnt_next;
                in_ready <= (cnt_next != 2'd2);   // registered, so no comb path to the lane
            end
        end

        always_ff @(posedge clk) begin
            if (pop) buf_mem[0] <= buf_mem[1];   // shift head out
            if (push) buf_mem[wr_slot] <= source_beat;
        end

        assign source_ready  = in_ready;
        assign lane_in_valid = (buf_cnt != 2'd0);
        assign lane_in_beat  = buf_mem[0];
    end else begin : g_no_buffer
        assign source_ready  = buf_ready;
        assign lane_in_valid = source_valid;
        assign lane_in_beat  = source_beat;
    end

    assign buf_ready   = grant && lane_in_ready[lane];
    assign grant_clear = buf_ready && lane_in_valid && lane_in_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant      <= 1'b0;
            grant_mask <= 1'b0;
        end else begin
            grant_mask <= arb_grant;
            if (grant_clear) grant <= 1'b0;   // packet done
            if (arb_grant) grant <= 1'b1;     // a new grant wins over the clear
        end
    end

    always_ff @(posedge clk) begin
        if (arb_grant) begin
            lane <= arb_grant_lane;
        end
    end

    // data on hand, free or finishing, no grant in flight, a command queued,
    // and the destination sink not held by anyone
    assign arb_req = lane_in_valid && (!grant || grant_clear) && !grant_mask
                     && !cmd_empty && sink_source[arb_req_sink];

    a_grant_overlap: assert property (@(posedge clk) disable iff (rst)
        arb_grant |-> (!grant || grant_clear))
        else $error("grant while a transfer is still active");

endmodule

//--- channel_source/cmd_fifo.sv
module cmd_fifo #(
    parameter int width = 4,
    parameter int depth = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [width-1:0] push_data,
    output logic             almost_full,
    input  logic             pop,
    output logic [width-1:0] pop_data,
    output logic             empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data    = mem[rd_ptr];
    assign empty       = (count == '0);
    assign almost_full = (count >= cnt_w'(depth - 1)); // one early, push is taken unchecked

    // the source pops one cycle after its grant, so an entry must still be there
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("command FIFO popped while empty");

endmodule

//--- common/router_beat_pkg.sv
package router_beat_pkg;

    // payload width of one beat
    localparam int data_w = 32;

    // one data beat as it moves from a source through a lane to a sink.
    // last marks the final beat of a packet and releases the lane
    typedef struct packed {
        logic              last;
        logic [data_w-1:0] data;
    } beat_t;

    // full width of a beat on the wires
    localparam int beat_w = $bits(beat_t);

endpackage

//--- common/router_ctrl_pkg.sv
package router_ctrl_pkg;

    // index fields in a route are sized for up to 16 sources, sinks or lanes
    localparam int route_idx_w = 4;

    // arbiter FSM
    typedef enum logic {
        scan,    // looking for a requester and a free lane
        settle   // one dead cycle so mask and busy bits catch up
    } arb_state_t;

    // what the arbiter tells the switch this cycle
    typedef enum logic {
        route_idle,
        route_set
    } route_op_t;

    typedef struct packed {
        route_op_t              op;
        logic [route_idx_w-1:0] src;
        logic [route_idx_w-1:0] sink;
        logic [route_idx_w-1:0] lane;
    } route_t;

    // index width for a count of n, never below one bit
    function automatic int idx_w(int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

//--- design/lane_arbiter.sv
module lane_arbiter #(
    parameter int  sources = 2,
    parameter int  sinks   = 2,
    parameter int  lanes   = 2,
    localparam int src_w   = router_ctrl_pkg::idx_w(sources),
    localparam int sink_w  = router_ctrl_pkg::idx_w(sinks),
    localparam int lane_w  = router_ctrl_pkg::idx_w(lanes)
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [sources-1:0]            arb_req,
    input  logic [sources-1:0][sink_w-1:0] arb_req_sink,
    output logic [sources-1:0]            arb_grant,
    output logic [lane_w-1:0]             arb_grant_lane,
    output logic [sinks-1:0]              sink_idle,
    output router_ctrl_pkg::route_t       route,
    input  logic [lanes-1:0]              lane_done,
    input  logic [lanes-1:0][sink_w-1:0]  lane_done_sink
);

    localparam int rw = router_ctrl_pkg::route_idx_w;

    router_ctrl_pkg::arb_state_t state;
    logic [src_w-1:0]  ptr;         // last source granted
    logic [lanes-1:0]  lane_busy;
    logic [sinks-1:0]  sink_busy;
    logic              req_hit;
    logic [src_w-1:0]  req_idx;
    logic              lane_free;
    logic [lane_w-1:0] free_lane;
    logic              grant_ok;

    // round robin, starting just after the last winner
    always_comb begin
        int cand;
        req_hit = 1'b0;
        req_idx = '0;
        for (int i = 0; i < sources; i++) begin
            cand = (int'(ptr) + 1 + i) % sources;
            if (!req_hit && arb_req[cand]) begin
                req_hit = 1'b1;
                req_idx = src_w'(cand);
            end
        end
    end

    // lowest free lane, descending loop so the lowest wins
    always_comb begin
        lane_free = 1'b0;
        free_lane = '0;
        for (int l = lanes - 1; l >= 0; l--) begin
            if (!lane_busy[l]) begin
                lane_free = 1'b1;
                free_lane = lane_w'(l);
            end
        end
    end

    assign grant_ok = (state == router_ctrl_pkg::scan) && req_hit && lane_free;

    always_comb begin
        arb_grant = '0;
        if (grant_ok) arb_grant[req_idx] = 1'b1;
    end

    assign arb_grant_lane = free_lane;
    assign sink_idle      = ~sink_busy;

    assign route.op   = grant_ok ? router_ctrl_pkg::route_set : router_ctrl_pkg::route_idle;
    assign route.src  = rw'(req_idx);
    assign route.sink = rw'(arb_req_sink[req_idx]);
    assign route.lane = rw'(free_lane);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= router_ctrl_pkg::scan;
            ptr       <= '0;
            lane_busy <= '0;
            sink_busy <= '0;
        end else begin
            for (int l = 0; l < lanes; l++) begin
                if (lane_done[l]) begin
                    lane_busy[l]                 <= 1'b0;
                    sink_busy[lane_done_sink[l]] <= 1'b0;
                end
            end
            if (grant_ok) begin
                lane_busy[free_lane]             <= 1'b1;
                sink_busy[arb_req_sink[req_idx]] <= 1'b1;
                ptr                              <= req_idx;
            end
            case (state)
                router_ctrl_pkg::scan:   if (grant_ok) state <= router_ctrl_pkg::settle;
                router_ctrl_pkg::settle: state <= router_ctrl_pkg::scan;
                default:                 state <= router_ctrl_pkg::scan;
            endcase
        end
    end

    // a source only asks for a sink it sees as idle
    a_grant_sink_free: assert property (@(posedge clk) disable iff (rst)
        grant_ok |-> !sink_busy[arb_req_sink[req_idx]])
        else $error("grant to a sink that is still busy");

endmodule

//--- design/lane_switch.sv
module lane_switch #(
    parameter int  sources = 2,
    parameter int  sinks   = 2,
    parameter int  lanes   = 2,
    localparam int src_w   = router_ctrl_pkg::idx_w(sources),
    localparam int sink_w  = router_ctrl_pkg::idx_w(sinks),
    localparam int lane_w  = router_ctrl_pkg::idx_w(lanes)
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  router_ctrl_pkg::route_t               route,
    input  logic [sources-1:0]                    lane_in_valid,
    input  router_beat_pkg::beat_t [sources-1:0]  lane_in_beat,
    output logic [lanes-1:0]                      lane_in_ready,
    output logic [sinks-1:0]                      sink_valid,
    output router_beat_pkg::beat_t [sinks-1:0]    sink_beat,
    output logic [sinks-1:0][src_w-1:0]           sink_src,
    input  logic [sinks-1:0]                      sink_ready,
    output logic [lanes-1:0]                      lane_done,
    output logic [lanes-1:0][sink_w-1:0]          lane_done_sink
);

    logic [lanes-1:0]             route_valid;
    logic [lanes-1:0][src_w-1:0]  route_src;
    logic [lanes-1:0][sink_w-1:0] route_sink;
    logic                         set;
    logic [lane_w-1:0]            set_lane;

    assign set      = (route.op == router_ctrl_pkg::route_set);
    assign set_lane = lane_w'(route.lane);

    always_ff @(posedge clk) begin
        if (rst) begin
            route_valid <= '0;
        end else begin
            for (int l = 0; l < lanes; l++) begin
                if (lane_done[l]) route_valid[l] <= 1'b0;   // released with the last beat
            end
            if (set) route_valid[set_lane] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (set) begin
            route_src[set_lane]  <= src_w'(route.src);
            route_sink[set_lane] <= sink_w'(route.sink);
        end
    end

    // each routed lane connects one source straight through to one sink
    always_comb begin
        lane_in_ready = '0;
        lane_done     = '0;
        sink_valid    = '0;
        sink_beat     = '0;
        sink_src      = '0;
        for (int l = 0; l < lanes; l++) begin
            lane_done_sink[l] = route_sink[l];
            if (route_valid[l]) begin
                lane_in_ready[l]          = sink_ready[route_sink[l]];
                sink_valid[route_sink[l]] = lane_in_valid[route_src[l]];
                sink_beat[route_sink[l]]  = lane_in_beat[route_src[l]];
                sink_src[route_sink[l]]   = route_src[l];
                lane_done[l] = lane_in_valid[route_src[l]] && sink_ready[route_sink[l]]
                               && lane_in_beat[route_src[l]].last;
            end
        end
    end

    // arbiter must only hand out lanes it sees as free
    a_lane_free: assert property (@(posedge clk) disable iff (rst) set |-> !route_valid[set_lane])
        else $error("route set on a lane that is still in use");

endmodule

//--- design/router_channel.sv
module router_channel #(
    parameter int  sources = 2,
    parameter int  sinks   = 2,
    parameter int  lanes   = 2,
    parameter int  mot     = 4,
    parameter int  buffer  = 1,
    localparam int src_w   = router_ctrl_pkg::idx_w(sources),
    localparam int sink_w  = router_ctrl_pkg::idx_w(sinks),
    localparam int lane_w  = router_ctrl_pkg::idx_w(lanes)
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [sources-1:0]                    cmd_push,
    input  logic [sources-1:0][sink_w-1:0]        cmd_sink,
    output logic [sources-1:0]                    cmd_full,
    input  logic [sources-1:0]                    source_valid,
    input  router_beat_pkg::beat_t [sources-1:0]  source_beat,
    output logic [sources-1:0]                    source_ready,
    output logic [sinks-1:0]                      sink_valid,
    output router_beat_pkg::beat_t [sinks-1:0]    sink_beat,
    output logic [sinks-1:0][src_w-1:0]           sink_src,
    input  logic [sinks-1:0]                      sink_ready
);

    logic [sources-1:0]                   arb_req;
    logic [sources-1:0][sink_w-1:0]       arb_req_sink;
    logic [sources-1:0]                   arb_grant;
    logic [lane_w-1:0]                    arb_grant_lane;
    logic [sinks-1:0]                     sink_idle;
    router_ctrl_pkg::route_t              route;
    logic [sources-1:0]                   lane_in_valid;
    router_beat_pkg::beat_t [sources-1:0] lane_in_beat;
    logic [lanes-1:0]                     lane_in_ready;
    logic [lanes-1:0]                     lane_done;
    logic [lanes-1:0][sink_w-1:0]         lane_done_sink;

    for (genvar s = 0; s < sources; s++) begin : g_source
        channel_source #(
            .sinks  (sinks),
            .lanes  (lanes),
            .mot    (mot),
            .buffer (buffer)
        ) u_source (
            .clk            (clk),
            .rst            (rst),
            .cmd_full       (cmd_full[s]),
            .cmd_push       (cmd_push[s]),
            .cmd_sink       (cmd_sink[s]),
            .source_ready   (source_ready[s]),
            .source_valid   (source_valid[s]),
            .source_beat    (source_beat[s]),
            .sink_source    (sink_idle),
            .arb_req        (arb_req[s]),
            .arb_req_sink   (arb_req_sink[s]),
            .arb_grant      (arb_grant[s]),
            .arb_grant_lane (arb_grant_lane),
            .lane_in_ready  (lane_in_ready),
            .lane_in_valid  (lane_in_valid[s]),
            .lane_in_beat   (lane_in_beat[s])
        );
    end

    lane_arbiter #(
        .sources (sources),
        .sinks   (sinks),
        .lanes   (lanes)
    ) u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .arb_req        (arb_req),
        .arb_req_sink   (arb_req_sink),
        .arb_grant      (arb_grant),
        .arb_grant_lane (arb_grant_lane),
        .sink_idle      (sink_idle),
        .route          (route),
        .lane_done      (lane_done),
        .lane_done_sink (lane_done_sink)
    );

    lane_switch #(
        .sources (sources),
        .sinks   (sinks),
        .lanes   (lanes)
    ) u_switch (
        .clk            (clk),
        .rst            (rst),
        .route          (route),
        .lane_in_valid  (lane_in_valid),
        .lane_in_beat   (lane_in_beat),
        .lane_in_ready  (lane_in_ready),
        .sink_valid     (sink_valid),
        .sink_beat      (sink_beat),
        .sink_src       (sink_src),
        .sink_ready     (sink_ready),
        .lane_done      (lane_done),
        .lane_done_sink (lane_done_sink)
    );

    // route fields carry 4-bit indices
    a_param_range: assert property (@(posedge clk)
        (sources <= 2 ** router_ctrl_pkg::route_idx_w) &&
        (sinks <= 2 ** router_ctrl_pkg::route_idx_w) &&
        (lanes <= 2 ** router_ctrl_pkg::route_idx_w))
        else $error("source, sink or lane count exceeds route index width");

endmodule

//--- list.f
common/router_beat_pkg.sv
common/router_ctrl_pkg.sv
channel_source/cmd_fifo.sv
channel_source/channel_source.sv
design/lane_arbiter.sv
design/lane_switch.sv
design/router_channel.sv
tests/router_channel_tb.sv

//--- tests/router_channel_tb.sv
module router_channel_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int sources     = 2;
    localparam int sinks       = 2;
    localparam int lanes       = 2;
    localparam int mot         = 4;
    localparam int buffer      = 1;
    localparam int src_w       = router_ctrl_pkg::idx_w(sources);
    localparam int sink_w      = router_ctrl_pkg::idx_w(sinks);
    localparam int num_packets = 200;
    localparam int max_len     = 4;
    localparam int max_cycles  = num_packets * max_len * 8 + 100; // 8 cycles a beat, plus reset

    typedef struct packed {
        logic [sink_w-1:0]      sink;
        router_beat_pkg::beat_t beat;
    } expect_t;

    logic                                 clk = 1'b0;
    logic                                 rst;
    logic [sources-1:0]                   cmd_push;
    logic [sources-1:0][sink_w-1:0]       cmd_sink;
    logic [sources-1:0]                   cmd_full;
    logic [sources-1:0]                   source_valid;
    router_beat_pkg::beat_t [sources-1:0] source_beat;
    logic [sources-1:0]                   source_ready;
    logic [sinks-1:0]                     sink_valid;
    router_beat_pkg::beat_t [sinks-1:0]   sink_beat;
    logic [sinks-1:0][src_w-1:0]          sink_src;
    logic [sinks-1:0]                     sink_ready;

    expect_t                exp_q [sources][$];  // beats still due at a sink
    router_beat_pkg::beat_t send_q [sources][$]; // beats the DUT has not taken yet
    logic [sources-1:0]          taken;          // source beat accepted at the coming edge
    logic [sinks-1:0]            pkt_active;
    logic [sinks-1:0][src_w-1:0] pkt_src;
    logic [31:0]                 lcg_state = 32'ha6cf1452;
    logic                        data_hold = 1'b0;
    int packets = 0;
    int beats_pushed = 0;
    int beats_seen = 0;
    int checks = 0;
    int errors = 0;
    int cycle_count = 0;

    always #50 clk = ~clk;

    router_channel #(
        .sources (sources),
        .sinks   (sinks),
        .lanes   (lanes),
        .mot     (mot),
        .buffer  (buffer)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .cmd_push     (cmd_push),
        .cmd_sink     (cmd_sink),
        .cmd_full     (cmd_full),
        .source_valid (source_valid),
        .source_beat  (source_beat),
        .source_ready (source_ready),
        .sink_valid   (sink_valid),
        .sink_beat    (sink_beat),
        .sink_src     (sink_src),
        .sink_ready   (sink_ready)
    );

    function automatic int rand_below(int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16]) % n;  // upper bits, the low ones cycle fast
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    // one command plus the beats of its packet, for the DUT and the model
    task automatic push_packet(int s, int sink, int len);
        router_beat_pkg::beat_t beat;
        expect_t e;
        cmd_push[s] = 1'b1;
        cmd_sink[s] = sink_w'(sink);
        for (int i = 0; i < len; i++) begin
            beat.last = (i == len - 1);
            beat.data = {16'(rand_below(65536)), 16'(rand_below(65536))};
            e.sink    = sink_w'(sink);
            e.beat    = beat;
            send_q[s].push_back(beat);
            exp_q[s].push_back(e);
        end
        packets++;
        beats_pushed += len;
    endtask

    task automatic push_random();
        for (int s = 0; s < sources; s++) begin
            if (packets < num_packets && !cmd_full[s] && rand_below(4) == 0) begin
                push_packet(s, rand_below(sinks), 1 + rand_below(max_len));
            end
        end
    endtask

    // sampled mid-cycle, everything settled
    task automatic monitor();
        expect_t e;
        int s;
        for (int i = 0; i < sources; i++) begin
            if (source_valid[i] && source_ready[i]) begin
                void'(send_q[i].pop_front());
                taken[i] = 1'b1;
            end
        end
        for (int k = 0; k < sinks; k++) begin
            if (sink_valid[k] && pkt_active[k]) begin
                check_value(32'(sink_src[k]), 32'(pkt_src[k]),
                            $sformatf("sink %0d changed source mid-packet", k));
            end
            if (sink_valid[k] && sink_ready[k]) begin
                s = int'(sink_src[k]);
                beats_seen++;
                if (exp_q[s].size() == 0) begin
                    errors++;
                    $display("extra beat at sink %0d from source %0d that was never sent", k, s);
                end else begin
                    e = exp_q[s].pop_front();
                    check_value(32'(k), 32'(e.sink), $sformatf("sink of source %0d beat", s));
                    check_value(sink_beat[k].data, e.beat.data, $sformatf("data at sink %0d", k));
                    check_value(32'(sink_beat[k].last), 32'(e.beat.last),
                                $sformatf("last flag at sink %0d", k));
                end
                pkt_active[k] = !sink_beat[k].last;
                pkt_src[k]    = sink_src[k];
            end
        end
    endtask

    task automatic drive_sources();
        for (int s = 0; s < sources; s++) begin
            if (!source_valid[s] || taken[s]) begin // valid holds until the beat is taken
                source_valid[s] = 1'b0;
                if (!data_hold && send_q[s].size() > 0 && rand_below(4) != 0) begin
                    source_valid[s] = 1'b1;
                    source_beat[s]  = send_q[s][0];
                end
            end
            taken[s] = 1'b0;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        monitor();
        @(posedge clk);
        #5;
        cmd_push = '0;
        drive_sources();
        for (int k = 0; k < sinks; k++) sink_ready[k] = (rand_below(4) != 0);
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int s = 0; s < sources; s++) n += exp_q[s].size();
        return n;
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout after %0d cycles with %0d beats undelivered", cycle_count,
                     pending());
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        cmd_push     = '0;
        cmd_sink     = '0;
        source_valid = '0;
        source_beat  = '0;
        sink_ready   = '0;
        taken        = '0;
        pkt_active   = '0;
        pkt_src      = '0;

        @(posedge clk);
        repeat (15) begin
            @(negedge clk);
            check_value(32'(sink_valid), 32'd0, "sink_valid during reset");
            check_value(32'(cmd_full), 32'd0, "cmd_full during reset");
            check_value(32'(source_ready), 32'd0, "source_ready during reset");
            @(posedge clk);
        end
        #5;
        rst = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value(32'(source_ready), (buffer > 0) ? 32'((1 << sources) - 1) : 32'd0,
                    "source_ready after reset");
        check_value(32'(sink_valid), 32'd0, "sink_valid after reset");
        @(posedge clk);
        #5;

        // fill source 0 up to the almost full mark, data held back
        data_hold = 1'b1;
        repeat (mot - 1) begin
            push_packet(0, rand_below(sinks), 1 + rand_below(max_len));
            next_cycle();
        end
        check_value(32'(cmd_full[0]), 32'd1, "cmd_full after the last allowed push");
        data_hold = 1'b0;

        while (packets < num_packets) begin
            push_random();
            next_cycle();
        end
        while (pending() > 0) next_cycle();
        repeat (50) next_cycle(); // drain, any beat now is extra
        check_value(beats_seen, beats_pushed, "beats delivered");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
